/* Bender.yml */
package:
  name: wb_stage

sources:
  - include_dirs:
      - design
    files:
      - design/wb_pkg.sv
      - design/load_align.sv
      - design/csr_timer.sv
      - design/csr_file.sv
      - design/wb_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/wb_checker.sv
      - tb/tb_top.sv

/* design/csr_file.sv */
`include "wb_macros.svh"

module csr_file (
	input  logic                     clk,
	input  logic                     reset,
	input  wb_pkg::csr_op_t          csr_op,
	input  logic [`WB_CSR_NUM_W-1:0] csr_num,
	input  logic [`WB_DATA_W-1:0]    wdata,
	input  logic [`WB_DATA_W-1:0]    mask,
	input  logic                     ex,
	input  wb_pkg::ecode_t           ecode,
	input  logic [`WB_DATA_W-1:0]    pc,
	input  logic                     ertn,
	output logic [`WB_DATA_W-1:0]    rdata,
	output logic                     crmd_ie,
	output logic [`WB_INT_W-1:0]     int_pending,
	output logic [`WB_DATA_W-1:0]    ex_entry,
	output logic [`WB_DATA_W-1:0]    era,
	output logic [63:0]              counter
);

	localparam logic [`WB_INT_W-1:0] LIE_RSVD = 1 << `ECFG_LIE_RSVD_BIT;

	logic [1:0]                        crmd_plv;
	logic                              crmd_da;
	logic                              crmd_pg;
	logic [1:0]                        crmd_datf;
	logic [1:0]                        crmd_datm;
	logic [1:0]                        prmd_pplv;
	logic                              prmd_pie;
	logic [`WB_INT_W-1:0]              ecfg_lie;
	logic [2:0]                        ecfg_vs;
	logic [1:0]                        estat_is_sw;
	wb_pkg::ecode_t                    estat_ecode;
	logic [`WB_INT_W-1:0]              estat_is;
	logic [`WB_DATA_W-1:`EENTRY_VA_LO] eentry_va;
	logic [`WB_DATA_W-1:0]             eentry;
	logic [`WB_DATA_W-1:0]             save [4];
	logic [`WB_DATA_W-1:0]             tid;
	logic [`WB_DATA_W-1:0]             tcfg;
	logic [`WB_DATA_W-1:0]             tval;
	logic                              timer_int;
	logic                              wr_en;
	logic                              save_hit;
	logic [`WB_DATA_W-1:0]             wr_val;

	function automatic logic hit(input logic [`WB_CSR_NUM_W-1:0] num);
		return wr_en && (csr_num == num);
	endfunction

	assign wr_en    = (csr_op == wb_pkg::CSR_OP_WRITE) || (csr_op == wb_pkg::CSR_OP_XCHG);
	assign save_hit = wr_en && (csr_num >= `CSR_SAVE0) && (csr_num <= `CSR_SAVE3);

	// Exchange merges under mask against the architectural read value
	assign wr_val = (csr_op == wb_pkg::CSR_OP_XCHG) ? ((mask & wdata) | (~mask & rdata)) : wdata;

	always_comb begin
		estat_is = '0;
		estat_is[1:0] = estat_is_sw;
		estat_is[`WB_TIMER_INT_BIT] = timer_int;
	end

	assign int_pending = estat_is & ecfg_lie;
	assign eentry      = {eentry_va, {`EENTRY_VA_LO{1'b0}}};
	assign ex_entry    = (ecfg_vs == 3'd0) ? eentry :
		(eentry | {{(`WB_DATA_W-`WB_ECODE_W-2){1'b0}}, ecode, 2'b00});

	always_comb begin
		case (csr_num)
			`CSR_CRMD:   rdata = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
			`CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
			`CSR_ECFG:   rdata = {13'b0, ecfg_vs, 3'b0, ecfg_lie};
			`CSR_ESTAT:  rdata = {10'b0, estat_ecode, 3'b0, estat_is};
			`CSR_ERA:    rdata = era;
			`CSR_EENTRY: rdata = eentry;
			`CSR_SAVE0,
			`CSR_SAVE1,
			`CSR_SAVE2,
			`CSR_SAVE3:  rdata = save[csr_num[1:0]];
			`CSR_TID:    rdata = tid;
			`CSR_TCFG:   rdata = tcfg;
			`CSR_TVAL:   rdata = tval;
			default:     rdata = '0;
		endcase
	end

	// CRMD, exception entry and return take priority over software writes
	always_ff @(posedge clk) begin
		if (reset) begin
			crmd_plv  <= 2'd0;
			crmd_ie   <= 1'b0;
			crmd_da   <= 1'b1;
			crmd_pg   <= 1'b0;
			crmd_datf <= 2'd0;
			crmd_datm <= 2'd0;
		end else if (ex) begin
			crmd_plv <= 2'd0;
			crmd_ie  <= 1'b0;
		end else if (ertn) begin
			crmd_plv <= prmd_pplv;
			crmd_ie  <= prmd_pie;
		end else if (hit(`CSR_CRMD)) begin
			crmd_plv  <= wr_val[1:0];
			crmd_ie   <= wr_val[2];
			crmd_da   <= wr_val[3];
			crmd_pg   <= wr_val[4];
			crmd_datf <= wr_val[6:5];
			crmd_datm <= wr_val[8:7];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prmd_pplv   <= 2'd0;
			prmd_pie    <= 1'b0;
			estat_is_sw <= 2'd0;
			estat_ecode <= '0;
		end else if (ex) begin
			prmd_pplv   <= crmd_plv;
			prmd_pie    <= crmd_ie;
			estat_ecode <= ecode;
		end else begin
			if (hit(`CSR_PRMD)) begin
				prmd_pplv <= wr_val[1:0];
				prmd_pie  <= wr_val[2];
			end
			// Only the two software interrupt bits are writable
			if (hit(`CSR_ESTAT)) begin
				estat_is_sw <= wr_val[1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ecfg_lie <= '0;
			ecfg_vs  <= 3'd0;
		end else if (hit(`CSR_ECFG)) begin
			ecfg_lie <= wr_val[`WB_INT_W-1:0] & ~LIE_RSVD;
			ecfg_vs  <= wr_val[`ECFG_VS_LO +: 3];
		end
	end

	always_ff @(posedge clk) begin
		if (ex) begin
			era <= pc;
		end else if (hit(`CSR_ERA)) begin
			era <= wr_val;
		end
		if (hit(`CSR_EENTRY)) begin
			eentry_va <= wr_val[`WB_DATA_W-1:`EENTRY_VA_LO];
		end
		if (hit(`CSR_TID)) begin
			tid <= wr_val;
		end
		if (save_hit) begin
			save[csr_num[1:0]] <= wr_val;
		end
	end

	csr_timer u_timer (
		.clk        (clk),
		.reset      (reset),
		.tcfg_we    (wr_en && (csr_num == `CSR_TCFG)),
		.tcfg_wdata (wr_val),
		.ticlr      (wr_en && (csr_num == `CSR_TICLR) && wr_val[0]),
		.tcfg       (tcfg),
		.tval       (tval),
		.timer_int  (timer_int),
		.counter    (counter)
	);

	a_ex_ertn_excl: assert property (
		@(posedge clk) disable iff (reset) !(ex && ertn)
	) else $error("exception and ertn strobes raised together");

endmodule

/* design/csr_timer.sv */
`include "wb_macros.svh"

module csr_timer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  tcfg_we,
	input  logic [`WB_DATA_W-1:0] tcfg_wdata,
	input  logic                  ticlr,
	output logic [`WB_DATA_W-1:0] tcfg,
	output logic [`WB_DATA_W-1:0] tval,
	output logic                  timer_int,
	output logic [63:0]           counter
);

	logic                                   tcfg_en;
	logic                                   tcfg_periodic;
	logic [`WB_DATA_W-`TCFG_INITVAL_LO-1:0] tcfg_initval;
	logic                                   armed;
	logic                                   tval_zero;
	logic                                   expire;

	assign tcfg      = {tcfg_initval, tcfg_periodic, tcfg_en};
	assign tval_zero = (tval == '0);
	assign expire    = tval_zero && tcfg_en && armed;

	// Stable counter, free running from reset
	always_ff @(posedge clk) begin
		if (reset) begin
			counter <= '0;
		end else begin
			counter <= counter + 64'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tcfg_en       <= 1'b0;
			tcfg_periodic <= 1'b0;
			tcfg_initval  <= '0;
		end else if (tcfg_we) begin
			tcfg_en       <= tcfg_wdata[0];
			tcfg_periodic <= tcfg_wdata[1];
			tcfg_initval  <= tcfg_wdata[`WB_DATA_W-1:`TCFG_INITVAL_LO];
		end
	end

	// Countdown; a one-shot timer disarms at zero and sits there
	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
			tval  <= '0;
		end else if (tcfg_we) begin
			armed <= tcfg_wdata[0];
			tval  <= {tcfg_wdata[`WB_DATA_W-1:`TCFG_INITVAL_LO], 2'b00};
		end else if (tcfg_en) begin
			if (!tval_zero) begin
				tval <= tval - 1'b1;
			end else if (tcfg_periodic) begin
				tval <= {tcfg_initval, 2'b00};
			end else begin
				armed <= 1'b0;
			end
		end
	end

	// Clear wins over a new expiry
	always_ff @(posedge clk) begin
		if (reset) begin
			timer_int <= 1'b0;
		end else if (ticlr) begin
			timer_int <= 1'b0;
		end else if (expire) begin
			timer_int <= 1'b1;
		end
	end

	a_int_needs_enable: assert property (
		@(posedge clk) disable iff (reset) $rose(timer_int) |-> $past(tcfg_en)
	) else $error("timer interrupt raised while TCFG enable was low");

endmodule

/* design/load_align.sv */
`include "wb_macros.svh"

module load_align (
	input  wb_pkg::wb_op_t        op,
	input  logic [1:0]            addr_lo,
	input  logic [`WB_DATA_W-1:0] mem_data,
	input  logic [`WB_DATA_W-1:0] alu_result,
	output logic [`WB_DATA_W-1:0] result
);

	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	always_comb begin
		case (addr_lo)
			2'b00: byte_sel = mem_data[7:0];
			2'b01: byte_sel = mem_data[15:8];
			2'b10: byte_sel = mem_data[23:16];
			default: byte_sel = mem_data[31:24];
		endcase
	end

	// Halfwords are aligned, only bit 1 picks the half
	assign half_sel = addr_lo[1] ? mem_data[31:16] : mem_data[15:0];

	always_comb begin
		case (op)
			wb_pkg::OP_LD_B:  result = {{(`WB_DATA_W-8){byte_sel[7]}}, byte_sel};
			wb_pkg::OP_LD_BU: result = {{(`WB_DATA_W-8){1'b0}}, byte_sel};
			wb_pkg::OP_LD_H:  result = {{(`WB_DATA_W-16){half_sel[15]}}, half_sel};
			wb_pkg::OP_LD_HU: result = {{(`WB_DATA_W-16){1'b0}}, half_sel};
			wb_pkg::OP_LD_W:  result = mem_data;
			default:          result = alu_result;
		endcase
	end

endmodule

/* design/wb_macros.svh */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// Datapath widths
`define WB_DATA_W        32
`define WB_REG_ADDR_W    5
`define WB_CSR_NUM_W     14
`define WB_ECODE_W       6
`define WB_INT_W         13
`define WB_TIMER_INT_BIT 11

// CSR numbers
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

`define ECODE_INT 6'h00

// Field positions
`define ECFG_VS_LO        16
`define ECFG_LIE_RSVD_BIT 10
`define EENTRY_VA_LO      12
`define TCFG_INITVAL_LO   2

`endif

/* design/wb_pkg.sv */
`include "wb_macros.svh"

package wb_pkg;

	// Instruction kind as seen by write-back
	typedef enum logic [3:0] {
		OP_ALU,
		OP_LD_B,
		OP_LD_H,
		OP_LD_BU,
		OP_LD_HU,
		OP_LD_W,
		OP_CSRRD,
		OP_CSRWR,
		OP_CSRXCHG,
		OP_ERTN,
		OP_RDTIMEL,
		OP_RDTIMEH
	} wb_op_t;

	// CSR access performed by the held instruction
	typedef enum logic [1:0] {
		CSR_OP_NONE,
		CSR_OP_READ,
		CSR_OP_WRITE,
		CSR_OP_XCHG
	} csr_op_t;

	// Exception cause, ESTAT.Ecode encoding
	typedef logic [`WB_ECODE_W-1:0] ecode_t;

endpackage

/* design/wb_stage.sv */
`include "wb_macros.svh"

module wb_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	output logic                      allowin,
	input  logic [`WB_DATA_W-1:0]     in_pc,
	input  wb_pkg::wb_op_t            in_op,
	input  logic [`WB_CSR_NUM_W-1:0]  in_csr_num,
	input  logic [`WB_DATA_W-1:0]     in_mask,
	input  logic [`WB_DATA_W-1:0]     in_alu_result,
	input  logic [`WB_DATA_W-1:0]     in_mem_result,
	input  logic [1:0]                in_addr_lo,
	input  logic                      in_ex,
	input  wb_pkg::ecode_t            in_ecode,
	input  logic                      in_gr_we,
	input  logic [`WB_REG_ADDR_W-1:0] in_dest,
	input  logic [`WB_REG_ADDR_W-1:0] in_rj_index,
	output logic                      rf_we,
	output logic [`WB_REG_ADDR_W-1:0] rf_waddr,
	output logic [`WB_DATA_W-1:0]     rf_wdata,
	output logic                      ex_flush,
	output logic                      ertn_flush,
	output logic [`WB_DATA_W-1:0]     redirect_pc
);

	logic                      ws_valid;
	logic [`WB_DATA_W-1:0]     ws_pc;
	wb_pkg::wb_op_t            ws_op;
	logic [`WB_CSR_NUM_W-1:0]  ws_csr_num;
	logic [`WB_DATA_W-1:0]     ws_mask;
	logic [`WB_DATA_W-1:0]     ws_alu_result;
	logic [`WB_DATA_W-1:0]     ws_mem_result;
	logic [1:0]                ws_addr_lo;
	logic                      ws_ex;
	wb_pkg::ecode_t            ws_ecode;
	logic                      ws_gr_we;
	logic [`WB_REG_ADDR_W-1:0] ws_dest;
	logic [`WB_REG_ADDR_W-1:0] ws_rj_index;

	wb_pkg::csr_op_t           csr_op;
	wb_pkg::ecode_t            cause;
	logic [`WB_DATA_W-1:0]     csr_rdata;
	logic                      crmd_ie;
	logic [`WB_INT_W-1:0]      int_pending;
	logic [`WB_DATA_W-1:0]     ex_entry;
	logic [`WB_DATA_W-1:0]     era;
	logic [63:0]               counter;
	logic [`WB_DATA_W-1:0]     align_result;
	logic                      is_csr;
	logic                      int_take;
	logic                      take_ex;

	// Never stalls
	assign allowin = 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			ws_valid <= 1'b0;
		end else if (allowin) begin
			// A flushing instruction squashes whatever arrives behind it
			ws_valid <= in_valid && !(ex_flush || ertn_flush);
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && allowin) begin
			ws_pc         <= in_pc;
			ws_op         <= in_op;
			ws_csr_num    <= in_csr_num;
			ws_mask       <= in_mask;
			ws_alu_result <= in_alu_result;
			ws_mem_result <= in_mem_result;
			ws_addr_lo    <= in_addr_lo;
			ws_ex         <= in_ex;
			ws_ecode      <= in_ecode;
			ws_gr_we      <= in_gr_we;
			ws_dest       <= in_dest;
			ws_rj_index   <= in_rj_index;
		end
	end

	assign is_csr = (ws_op == wb_pkg::OP_CSRRD) || (ws_op == wb_pkg::OP_CSRWR) ||
		(ws_op == wb_pkg::OP_CSRXCHG);

	// Interrupt overrides whatever exception the instruction carried
	assign int_take   = ws_valid && (int_pending != '0) && crmd_ie;
	assign take_ex    = ws_valid && (ws_ex || int_take);
	assign cause      = int_take ? `ECODE_INT : ws_ecode;
	assign ex_flush   = take_ex;
	assign ertn_flush = ws_valid && (ws_op == wb_pkg::OP_ERTN) && !take_ex;
	assign redirect_pc = ex_flush ? ex_entry : era;

	always_comb begin
		csr_op = wb_pkg::CSR_OP_NONE;
		if (ws_valid && !take_ex) begin
			case (ws_op)
				wb_pkg::OP_CSRRD: csr_op = wb_pkg::CSR_OP_READ;
				wb_pkg::OP_CSRWR: csr_op = wb_pkg::CSR_OP_WRITE;
				wb_pkg::OP_CSRXCHG: begin
					// rj of r0 or r1 in the xchg encoding means csrrd or csrwr
					if (ws_rj_index == 0) begin
						csr_op = wb_pkg::CSR_OP_READ;
					end else if (ws_rj_index == 1) begin
						csr_op = wb_pkg::CSR_OP_WRITE;
					end else begin
						csr_op = wb_pkg::CSR_OP_XCHG;
					end
				end
				default: csr_op = wb_pkg::CSR_OP_NONE;
			endcase
		end
	end

	csr_file u_csr (
		.clk         (clk),
		.reset       (reset),
		.csr_op      (csr_op),
		.csr_num     (ws_csr_num),
		.wdata       (ws_alu_result),
		.mask        (ws_mask),
		.ex          (take_ex),
		.ecode       (cause),
		.pc          (ws_pc),
		.ertn        (ertn_flush),
		.rdata       (csr_rdata),
		.crmd_ie     (crmd_ie),
		.int_pending (int_pending),
		.ex_entry    (ex_entry),
		.era         (era),
		.counter     (counter)
	);

	load_align u_align (
		.op         (ws_op),
		.addr_lo    (ws_addr_lo),
		.mem_data   (ws_mem_result),
		.alu_result (ws_alu_result),
		.result     (align_result)
	);

	always_comb begin
		if (is_csr) begin
			rf_wdata = csr_rdata;
		end else if (ws_op == wb_pkg::OP_RDTIMEL) begin
			rf_wdata = counter[31:0];
		end else if (ws_op == wb_pkg::OP_RDTIMEH) begin
			rf_wdata = counter[63:32];
		end else begin
			rf_wdata = align_result;
		end
	end

	assign rf_we    = ws_valid && !take_ex && ws_gr_we;
	assign rf_waddr = ws_dest;

	a_no_write_on_flush: assert property (
		@(posedge clk) disable iff (reset) !(rf_we && ex_flush)
	) else $error("register write issued alongside an exception flush");

endmodule

/* tb.f */
+incdir+design
design/wb_pkg.sv
design/load_align.sv
design/csr_timer.sv
design/csr_file.sv
design/wb_stage.sv
tb/wb_checker.sv
tb/tb_top.sv

/* tb/tb_top.sv */
`include "wb_macros.svh"

module tb_top;

	localparam int POLL_LIMIT = 200;

	logic                      clk;
	logic                      reset;
	logic                      in_valid;
	logic                      allowin;
	logic [`WB_DATA_W-1:0]     in_pc;
	wb_pkg::wb_op_t            in_op;
	logic [`WB_CSR_NUM_W-1:0]  in_csr_num;
	logic [`WB_DATA_W-1:0]     in_mask;
	logic [`WB_DATA_W-1:0]     in_alu_result;
	logic [`WB_DATA_W-1:0]     in_mem_result;
	logic [1:0]                in_addr_lo;
	logic                      in_ex;
	wb_pkg::ecode_t            in_ecode;
	logic                      in_gr_we;
	logic [`WB_REG_ADDR_W-1:0] in_dest;
	logic [`WB_REG_ADDR_W-1:0] in_rj_index;
	logic                      rf_we;
	logic [`WB_REG_ADDR_W-1:0] rf_waddr;
	logic [`WB_DATA_W-1:0]     rf_wdata;
	logic                      ex_flush;
	logic                      ertn_flush;
	logic [`WB_DATA_W-1:0]     redirect_pc;
	int                        checker_errors;
	int                        timeouts;
	logic [31:0]               lcg_state;

	wb_stage UUT (
		.clk(clk), .reset(reset), .in_valid(in_valid), .allowin(allowin),
		.in_pc(in_pc), .in_op(in_op), .in_csr_num(in_csr_num), .in_mask(in_mask),
		.in_alu_result(in_alu_result), .in_mem_result(in_mem_result),
		.in_addr_lo(in_addr_lo), .in_ex(in_ex), .in_ecode(in_ecode),
		.in_gr_we(in_gr_we), .in_dest(in_dest), .in_rj_index(in_rj_index),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.ex_flush(ex_flush), .ertn_flush(ertn_flush), .redirect_pc(redirect_pc)
	);

	wb_checker u_checker (
		.clk(clk), .reset(reset), .in_valid(in_valid), .allowin(allowin),
		.in_pc(in_pc), .in_op(in_op),
		.in_csr_num(in_csr_num), .in_mask(in_mask), .in_alu_result(in_alu_result),
		.in_mem_result(in_mem_result), .in_addr_lo(in_addr_lo), .in_ex(in_ex),
		.in_ecode(in_ecode), .in_gr_we(in_gr_we), .in_dest(in_dest),
		.in_rj_index(in_rj_index), .rf_we(rf_we), .rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata), .ex_flush(ex_flush), .ertn_flush(ertn_flush),
		.redirect_pc(redirect_pc), .error_count(checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] random_word();
		lcg_state = lcg_step(lcg_state);
		return lcg_state;
	endfunction

	function automatic logic [`WB_CSR_NUM_W-1:0] tested_csr(input int i);
		case (i)
			0: return `CSR_SAVE0;
			1: return `CSR_SAVE1;
			2: return `CSR_SAVE2;
			3: return `CSR_SAVE3;
			4: return `CSR_ERA;
			5: return `CSR_EENTRY;
			6: return `CSR_ECFG;
			default: return `CSR_PRMD;
		endcase
	endfunction

	// One instruction per cycle, presented on the falling edge
	task automatic send(input wb_pkg::wb_op_t op, input logic [13:0] num,
		input logic [31:0] alu, input logic [31:0] mask, input logic [1:0] addr_lo,
		input logic ex, input logic [5:0] ecode, input logic gr_we);
		@(negedge clk);
		in_valid      = 1'b1;
		in_op         = op;
		in_csr_num    = num;
		in_alu_result = alu;
		in_mask       = mask;
		in_addr_lo    = addr_lo;
		in_ex         = ex;
		in_ecode      = ecode;
		in_gr_we      = gr_we;
		in_pc         = random_word() & 32'hffff_fffc;
		in_mem_result = random_word();
		in_dest       = random_word() % 32;
		in_rj_index   = 5'd4;
	endtask

	task automatic csr_access(input wb_pkg::wb_op_t op, input logic [13:0] num,
		input logic [31:0] val, input logic [31:0] mask);
		send(op, num, val, mask, 2'b00, 1'b0, 6'h00, 1'b1);
	endtask

	initial begin
		logic [31:0] v;
		int          polls;
		lcg_state     = 32'hea06_ca6f;
		timeouts      = 0;
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_pc         = '0;
		in_op         = wb_pkg::OP_ALU;
		in_csr_num    = '0;
		in_mask       = '0;
		in_alu_result = '0;
		in_mem_result = '0;
		in_addr_lo    = '0;
		in_ex         = 1'b0;
		in_ecode      = '0;
		in_gr_we      = 1'b0;
		in_dest       = '0;
		in_rj_index   = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Registers without reset get a known value, no GR write
		for (int i = 0; i < 6; i++) begin
			send(wb_pkg::OP_CSRWR, tested_csr(i), random_word(), '0, 2'b00, 1'b0, 6'h00, 1'b0);
		end

		for (int k = 1; k <= 5; k++) begin
			for (int a = 0; a < 4; a++) begin
				send(wb_pkg::wb_op_t'(k), '0, random_word(), '0, a[1:0], 1'b0, 6'h00, 1'b1);
			end
		end
		repeat (4) csr_access(wb_pkg::OP_ALU, '0, random_word(), '0);

		for (int i = 0; i < 8; i++) begin
			csr_access(wb_pkg::OP_CSRWR, tested_csr(i), random_word(), '0);
			csr_access(wb_pkg::OP_CSRXCHG, tested_csr(i), random_word(), random_word());
			csr_access(wb_pkg::OP_CSRRD, tested_csr(i), random_word(), '0);
		end

		// Exception entry with ECFG.VS zero and nonzero, each followed by ertn
		for (int vs = 0; vs < 2; vs++) begin
			csr_access(wb_pkg::OP_CSRWR, `CSR_ECFG, vs << `ECFG_VS_LO, '0);
			csr_access(wb_pkg::OP_CSRWR, `CSR_CRMD, 32'h0000_000b, '0);
			v = random_word();
			send(wb_pkg::OP_ALU, '0, random_word(), '0, 2'b00, 1'b1, v[5:0] | 6'h01, 1'b1);
			// Lands in the flush cycle and must be dropped
			csr_access(wb_pkg::OP_ALU, '0, random_word(), '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_ERA, '0, '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_PRMD, '0, '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_ESTAT, '0, '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_CRMD, '0, '0);
			send(wb_pkg::OP_ERTN, '0, '0, '0, 2'b00, 1'b0, 6'h00, 1'b0);
			// Dropped behind the ertn flush
			csr_access(wb_pkg::OP_ALU, '0, random_word(), '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_CRMD, '0, '0);
			csr_access(wb_pkg::OP_CSRRD, `CSR_PRMD, '0, '0);
		end

		// One-shot timer with initial value 8
		csr_access(wb_pkg::OP_CSRWR, `CSR_ECFG, 32'h0000_0800, '0);
		csr_access(wb_pkg::OP_CSRWR, `CSR_TCFG, 32'h0000_0009, '0);
		csr_access(wb_pkg::OP_CSRWR, `CSR_CRMD, 32'h0000_000c, '0);
		polls = 0;
		while (!ex_flush && polls < POLL_LIMIT) begin
			csr_access(wb_pkg::OP_ALU, '0, random_word(), '0);
			polls++;
		end
		if (!ex_flush) begin
			$display("timeout: timer interrupt was not taken within %0d instructions", POLL_LIMIT);
			timeouts++;
		end
		csr_access(wb_pkg::OP_CSRRD, `CSR_ESTAT, '0, '0);
		csr_access(wb_pkg::OP_CSRWR, `CSR_TICLR, 32'h0000_0001, '0);
		csr_access(wb_pkg::OP_CSRRD, `CSR_ESTAT, '0, '0);

		repeat (4) csr_access(wb_pkg::OP_RDTIMEL, '0, '0, '0);
		repeat (2) csr_access(wb_pkg::OP_RDTIMEH, '0, '0, '0);

		@(negedge clk);
		in_valid = 1'b0;
		repeat (3) @(negedge clk);
		$display("checker errors: %0d, timeouts: %0d", checker_errors, timeouts);
		if (checker_errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* tb/wb_checker.sv */
`include "wb_macros.svh"

module wb_checker (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  logic                      allowin,
	input  logic [`WB_DATA_W-1:0]     in_pc,
	input  wb_pkg::wb_op_t            in_op,
	input  logic [`WB_CSR_NUM_W-1:0]  in_csr_num,
	input  logic [`WB_DATA_W-1:0]     in_mask,
	input  logic [`WB_DATA_W-1:0]     in_alu_result,
	input  logic [`WB_DATA_W-1:0]     in_mem_result,
	input  logic [1:0]                in_addr_lo,
	input  logic                      in_ex,
	input  wb_pkg::ecode_t            in_ecode,
	input  logic                      in_gr_we,
	input  logic [`WB_REG_ADDR_W-1:0] in_dest,
	input  logic [`WB_REG_ADDR_W-1:0] in_rj_index,
	input  logic                      rf_we,
	input  logic [`WB_REG_ADDR_W-1:0] rf_waddr,
	input  logic [`WB_DATA_W-1:0]     rf_wdata,
	input  logic                      ex_flush,
	input  logic                      ertn_flush,
	input  logic [`WB_DATA_W-1:0]     redirect_pc,
	output int                        error_count
);

	int errors = 0;

	// Shadow of the held instruction
	logic                      h_valid;
	logic [`WB_DATA_W-1:0]     h_pc;
	wb_pkg::wb_op_t            h_op;
	logic [`WB_CSR_NUM_W-1:0]  h_csr_num;
	logic [`WB_DATA_W-1:0]     h_mask;
	logic [`WB_DATA_W-1:0]     h_alu;
	logic [`WB_DATA_W-1:0]     h_mem;
	logic [1:0]                h_addr_lo;
	logic                      h_ex;
	wb_pkg::ecode_t            h_ecode;
	logic                      h_gr_we;
	logic [`WB_REG_ADDR_W-1:0] h_dest;
	logic [`WB_REG_ADDR_W-1:0] h_rj;

	// Shadow CSR state
	logic [8:0]                m_crmd;
	logic [2:0]                m_prmd;
	logic [`WB_INT_W-1:0]      m_lie;
	logic [2:0]                m_vs;
	logic [1:0]                m_sw;
	wb_pkg::ecode_t            m_ecode;
	logic [`WB_DATA_W-1:0]     m_era;
	logic [19:0]               m_eentry_va;
	logic [`WB_DATA_W-1:0]     m_save [4];
	logic [`WB_DATA_W-1:0]     m_tid;
	logic                      m_t_en;
	logic                      m_t_per;
	logic [29:0]               m_t_init;
	logic                      m_armed;
	logic [`WB_DATA_W-1:0]     m_tval;
	logic                      m_tint;
	logic [63:0]               m_counter;

	assign error_count = errors;

	function automatic logic [`WB_INT_W-1:0] estat_is();
		return {1'b0, m_tint, 9'b0, m_sw};
	endfunction

	function automatic logic [`WB_DATA_W-1:0] csr_value(input logic [`WB_CSR_NUM_W-1:0] num);
		case (num)
			`CSR_CRMD:   return {23'b0, m_crmd};
			`CSR_PRMD:   return {29'b0, m_prmd};
			`CSR_ECFG:   return {13'b0, m_vs, 3'b0, m_lie};
			`CSR_ESTAT:  return {10'b0, m_ecode, 3'b0, estat_is()};
			`CSR_ERA:    return m_era;
			`CSR_EENTRY: return {m_eentry_va, 12'b0};
			`CSR_SAVE0,
			`CSR_SAVE1,
			`CSR_SAVE2,
			`CSR_SAVE3:  return m_save[num[1:0]];
			`CSR_TID:    return m_tid;
			`CSR_TCFG:   return {m_t_init, m_t_per, m_t_en};
			`CSR_TVAL:   return m_tval;
			default:     return '0;
		endcase
	endfunction

	// Expected register write data of the held instruction
	function automatic logic [`WB_DATA_W-1:0] expected_result(
		input wb_pkg::wb_op_t        op,
		input logic [1:0]            a,
		input logic [`WB_DATA_W-1:0] w,
		input logic [`WB_DATA_W-1:0] alu,
		input logic [`WB_DATA_W-1:0] csr_old,
		input logic [63:0]           cnt
	);
		logic [7:0]  b;
		logic [15:0] h;
		b = w[8*a +: 8];
		h = w[16*a[1] +: 16];
		case (op)
			wb_pkg::OP_LD_B:    return {{24{b[7]}}, b};
			wb_pkg::OP_LD_BU:   return {24'b0, b};
			wb_pkg::OP_LD_H:    return {{16{h[15]}}, h};
			wb_pkg::OP_LD_HU:   return {16'b0, h};
			wb_pkg::OP_LD_W:    return w;
			wb_pkg::OP_CSRRD,
			wb_pkg::OP_CSRWR,
			wb_pkg::OP_CSRXCHG: return csr_old;
			wb_pkg::OP_RDTIMEL: return cnt[31:0];
			wb_pkg::OP_RDTIMEH: return cnt[63:32];
			default:            return alu;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
			errors++;
		end
	endtask

	always @(posedge clk) begin : compare_and_update
		logic [`WB_INT_W-1:0]  pending;
		logic                  int_take;
		logic                  exp_ex;
		logic                  exp_ertn;
		logic                  exp_we;
		wb_pkg::ecode_t        cause;
		logic [`WB_DATA_W-1:0] entry;
		logic [`WB_DATA_W-1:0] old;
		logic [`WB_DATA_W-1:0] wval;
		logic                  writes;
		logic                  expire;
		if (reset) begin
			h_valid   = 1'b0;
			m_crmd    = 9'h008;
			m_prmd    = '0;
			m_lie     = '0;
			m_vs      = '0;
			m_sw      = '0;
			m_ecode   = '0;
			m_t_en    = 1'b0;
			m_t_per   = 1'b0;
			m_t_init  = '0;
			m_armed   = 1'b0;
			m_tval    = '0;
			m_tint    = 1'b0;
			m_counter = '0;
		end else begin
			pending  = estat_is() & m_lie;
			int_take = h_valid && (pending != '0) && m_crmd[2];
			exp_ex   = h_valid && (h_ex || int_take);
			cause    = int_take ? `ECODE_INT : h_ecode;
			exp_ertn = h_valid && (h_op == wb_pkg::OP_ERTN) && !exp_ex;
			exp_we   = h_valid && !exp_ex && h_gr_we;
			entry    = {m_eentry_va, 12'b0};
			if (m_vs != 3'd0) begin
				entry = entry | {24'b0, cause, 2'b00};
			end
			old = csr_value(h_csr_num);

			// The stage never stalls
			check_value("allowin", allowin, 1'b1);
			check_value("rf_we", rf_we, exp_we);
			check_value("ex_flush", ex_flush, exp_ex);
			check_value("ertn_flush", ertn_flush, exp_ertn);
			if (exp_we) begin
				check_value("rf_waddr", rf_waddr, h_dest);
				check_value("rf_wdata", rf_wdata,
					expected_result(h_op, h_addr_lo, h_mem, h_alu, old, m_counter));
			end
			if (exp_ex) begin
				check_value("redirect_pc", redirect_pc, entry);
			end else if (exp_ertn) begin
				check_value("redirect_pc", redirect_pc, m_era);
			end

			// csrxchg with rj 0 reads only, with rj 1 writes plainly
			writes = h_valid && !exp_ex && ((h_op == wb_pkg::OP_CSRWR) ||
				((h_op == wb_pkg::OP_CSRXCHG) && (h_rj != 0)));
			wval = h_alu;
			if ((h_op == wb_pkg::OP_CSRXCHG) && (h_rj > 1)) begin
				wval = (h_mask & h_alu) | (~h_mask & old);
			end
			expire = (m_tval == '0) && m_t_en && m_armed;

			if (writes) begin
				case (h_csr_num)
					`CSR_CRMD:   m_crmd = wval[8:0];
					`CSR_PRMD:   m_prmd = wval[2:0];
					`CSR_ESTAT:  m_sw = wval[1:0];
					`CSR_ERA:    m_era = wval;
					`CSR_EENTRY: m_eentry_va = wval[31:12];
					`CSR_TID:    m_tid = wval;
					`CSR_ECFG: begin
						m_lie     = wval[`WB_INT_W-1:0];
						m_lie[10] = 1'b0;
						m_vs      = wval[18:16];
					end
					`CSR_SAVE0,
					`CSR_SAVE1,
					`CSR_SAVE2,
					`CSR_SAVE3:  m_save[h_csr_num[1:0]] = wval;
					default: ;
				endcase
			end

			if (writes && (h_csr_num == `CSR_TICLR) && wval[0]) begin
				m_tint = 1'b0;
			end else if (expire) begin
				m_tint = 1'b1;
			end
			if (writes && (h_csr_num == `CSR_TCFG)) begin
				m_t_en   = wval[0];
				m_t_per  = wval[1];
				m_t_init = wval[31:2];
				m_armed  = wval[0];
				m_tval   = {wval[31:2], 2'b00};
			end else if (m_t_en) begin
				if (m_tval != '0) begin
					m_tval = m_tval - 1;
				end else if (m_t_per) begin
					m_tval = {m_t_init, 2'b00};
				end else begin
					m_armed = 1'b0;
				end
			end

			if (exp_ex) begin
				m_prmd      = m_crmd[2:0];
				m_crmd[2:0] = 3'b000;
				m_ecode     = cause;
				m_era       = h_pc;
			end else if (exp_ertn) begin
				m_crmd[2:0] = m_prmd;
			end
			m_counter = m_counter + 1;

			// Next held instruction
			if (in_valid) begin
				h_pc      = in_pc;
				h_op      = in_op;
				h_csr_num = in_csr_num;
				h_mask    = in_mask;
				h_alu     = in_alu_result;
				h_mem     = in_mem_result;
				h_addr_lo = in_addr_lo;
				h_ex      = in_ex;
				h_ecode   = in_ecode;
				h_gr_we   = in_gr_we;
				h_dest    = in_dest;
				h_rj      = in_rj_index;
			end
			h_valid = in_valid && !(exp_ex || exp_ertn);
		end
	end

endmodule
